// ==== Bender.yml ====
package:
  name: credit_link

sources:
  - credit_link_pkg.sv
  - credit_counter.sv
  - credit_receiver.sv
  - credit_rx_lane.sv
  - credit_sender.sv
  - lane_drain_arbiter.sv
  - credit_link_top.sv
  - target: simulation
    files:
      - credit_link_checker.sv
      - tb_credit_link.sv

// ==== credit_counter.sv ====
`timescale 1ns/1ps

module credit_counter (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                incr,
  input  logic                decr_valid,
  output logic                decr_ready,
  input  credit_link_pkg::cnt_t withhold,
  output credit_link_pkg::cnt_t value,
  output credit_link_pkg::cnt_t available
);

  import credit_link_pkg::*;

  // One extra bit so that the sum with a returned credit cannot wrap.
  logic [CNT_W:0] value_incr;
  logic [CNT_W:0] value_next;
  logic [CNT_W:0] withhold_ext;
  logic           decr_fire;

  // --------------------------------------------------
  // Available credit
  // --------------------------------------------------

  // A credit returned this cycle is counted at once, so it can go
  // straight back out on the decrement side.
  assign value_incr   = {1'b0, value} + {{CNT_W{1'b0}}, incr};
  assign withhold_ext = {1'b0, withhold};

  // Withheld credits are taken off the top.
  // If more is withheld than is held, nothing is available.
  assign available = (value_incr > withhold_ext) ? cnt_t'(value_incr - withhold_ext) : '0;

  // A decrement is only granted while at least one credit is available.
  assign decr_ready = (available != '0);
  assign decr_fire  = decr_valid && decr_ready;

  // --------------------------------------------------
  // Count register
  // --------------------------------------------------

  assign value_next = value_incr - {{CNT_W{1'b0}}, decr_fire};

  // The count starts full, since the buffer is empty after reset.
  // It saturates at full credit in case of a stray return.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      value <= CNT_MAX;
    end else if (value_next > {1'b0, CNT_MAX}) begin
      value <= CNT_MAX;
    end else begin
      value <= cnt_t'(value_next);
    end
  end

endmodule

// ==== credit_link_checker.sv ====
`timescale 1ns/1ps

module credit_link_checker (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  push_credit_stall,
  input logic                  push_credit,
  input logic                  push_valid,
  input credit_link_pkg::cnt_t credit_withhold,
  input credit_link_pkg::cnt_t credit_count
);

  import credit_link_pkg::*;

  // Number of failed assertions in this lane.
  int unsigned fail_count = 0;

  // --------------------------------------------------
  // Credit issue rules
  // --------------------------------------------------

  // A stalled receiver puts no credit on the link one cycle later.
  // Its counter gives nothing away in that cycle either.
  stall_blocks_credit: assert property (@(posedge clk) disable iff (!rst_n)
    push_credit_stall |=> !push_credit && (credit_count >= $past(credit_count)))
  else begin
    fail_count++;
    $error("Credit issued one cycle after a stall");
  end

  // With more withheld than held, even a returning credit cannot be granted.
  withhold_blocks_credit: assert property (@(posedge clk) disable iff (!rst_n)
    (credit_withhold > credit_count) |=> !push_credit)
  else begin
    fail_count++;
    $error("Credit granted while the withhold exceeded the count");
  end

  // A full counter means no credit is out, so no word can be on its way.
  no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
    push_valid |-> (credit_count != CNT_MAX))
  else begin
    fail_count++;
    $error("Word pushed while the credit counter was full");
  end

endmodule

bind credit_receiver credit_link_checker checker_i (
  .clk               (clk),
  .rst_n             (rst_n),
  .push_credit_stall (push_credit_stall),
  .push_credit       (push_credit),
  .push_valid        (push_valid),
  .credit_withhold   (credit_withhold),
  .credit_count      (credit_count)
);

// ==== credit_link_pkg.sv ====
package credit_link_pkg;

  // --------------------------------------------------
  // Link sizes
  // --------------------------------------------------

  // Number of receive lanes behind the sender.
  localparam int NUM_LANES = 4;

  // Buffer slots per lane. This is also the credit a lane grants at reset.
  localparam int LANE_DEPTH = 4;

  // Payload width of every word on the link.
  localparam int DATA_W = 16;

  // A credit count must hold every value from 0 up to LANE_DEPTH.
  localparam int CNT_W = $clog2(LANE_DEPTH + 1);

  // Width of a lane number.
  localparam int LANE_W = $clog2(NUM_LANES);

  // Width of a read or write pointer into one lane buffer.
  localparam int PTR_W = $clog2(LANE_DEPTH);

  // --------------------------------------------------
  // Types
  // --------------------------------------------------

  typedef logic [LANE_W-1:0] lane_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [CNT_W-1:0] cnt_t;
  typedef logic [PTR_W-1:0] ptr_t;

  // Full credit as a count value, used for reset and saturation.
  localparam cnt_t CNT_MAX = cnt_t'(LANE_DEPTH);

endpackage

// ==== credit_link_testdata.txt ====
// One hex word per line: test number (1 digit), lane (1 digit), data or count (4 digits).
// Tests 1, 4 and 5 give the expected held count per lane; test f marks the end.
100004
20a001
21b001
22c001
23d001
20a002
20a003
21b002
23d002
23d003
22c002
20a004
20a005
21b003
22c003
23d004
20a006
400003
500004
f00000

// ==== credit_link_top.sv ====
`timescale 1ns/1ps

module credit_link_top (
  input  logic                   clk,
  input  logic                   rst_n,
  // Input stream.
  input  logic                   in_valid,
  output logic                   in_ready,
  input  credit_link_pkg::lane_t in_lane,
  input  credit_link_pkg::data_t in_data,
  // Credit control shared by all lanes.
  input  credit_link_pkg::cnt_t  credit_withhold,
  input  logic                   credit_stall,
  // Merged output stream.
  output logic                   out_valid,
  input  logic                   out_ready,
  output credit_link_pkg::lane_t out_lane,
  output credit_link_pkg::data_t out_data
);

  import credit_link_pkg::*;

  // Credit/valid link between the sender and the lanes.
  logic [NUM_LANES-1:0]  lane_credit;
  logic [NUM_LANES-1:0]  lane_valid;
  data_t                 lane_data;

  // Drain side between the lanes and the arbiter.
  logic [NUM_LANES-1:0]  head_valid;
  data_t [NUM_LANES-1:0] head_data;
  logic [NUM_LANES-1:0]  pop;

  // --------------------------------------------------
  // Sender
  // --------------------------------------------------

  credit_sender sender_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_lane     (in_lane),
    .in_data     (in_data),
    .lane_credit (lane_credit),
    .lane_valid  (lane_valid),
    .lane_data   (lane_data)
  );

  // --------------------------------------------------
  // Receive lanes
  // --------------------------------------------------

  // All lanes see the same payload and are told apart by their valid bit.
  for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane
    credit_rx_lane lane_i (
      .clk             (clk),
      .rst_n           (rst_n),
      .lane_valid      (lane_valid[i]),
      .lane_data       (lane_data),
      .lane_credit     (lane_credit[i]),
      .credit_withhold (credit_withhold),
      .credit_stall    (credit_stall),
      .pop             (pop[i]),
      .head_valid      (head_valid[i]),
      .head_data       (head_data[i])
    );
  end

  // Round-robin merge into the output stream.
  lane_drain_arbiter arbiter_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .head_valid (head_valid),
    .head_data  (head_data),
    .pop        (pop),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_lane   (out_lane),
    .out_data   (out_data)
  );

endmodule

// ==== credit_receiver.sv ====
`timescale 1ns/1ps

module credit_receiver (
  input  logic                   clk,
  input  logic                   rst_n,
  // Push side, facing the sender over the link.
  input  logic                   push_credit_stall,
  output logic                   push_credit,
  input  logic                   push_valid,
  input  credit_link_pkg::data_t push_data,
  // Pop side, wired straight to the lane buffer.
  input  logic                   pop_credit,
  output logic                   pop_valid,
  output credit_link_pkg::data_t pop_data,
  // Credit control and status.
  input  credit_link_pkg::cnt_t  credit_withhold,
  output credit_link_pkg::cnt_t  credit_count,
  output credit_link_pkg::cnt_t  credit_available
);

  logic credit_decr_valid;
  logic credit_decr_ready;
  logic push_credit_next;

  // --------------------------------------------------
  // Credit accounting
  // --------------------------------------------------

  // Every word popped from the buffer frees one slot and so returns
  // one credit to the counter.
  credit_counter counter_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .incr       (pop_credit),
    .decr_valid (credit_decr_valid),
    .decr_ready (credit_decr_ready),
    .withhold   (credit_withhold),
    .value      (credit_count),
    .available  (credit_available)
  );

  // We try to issue a credit every cycle unless the sender side is stalled.
  assign credit_decr_valid = !push_credit_stall;
  assign push_credit_next  = credit_decr_valid && credit_decr_ready;

  // The credit pulse is registered once, which models one cycle of link delay.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      push_credit <= 1'b0;
    end else begin
      push_credit <= push_credit_next;
    end
  end

  // No storage on the data path. The buffer behind us holds the words.
  assign pop_valid = push_valid;
  assign pop_data  = push_data;

endmodule

// ==== credit_rx_lane.sv ====
`timescale 1ns/1ps

module credit_rx_lane (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   lane_valid,
  input  credit_link_pkg::data_t lane_data,
  output logic                   lane_credit,
  input  credit_link_pkg::cnt_t  credit_withhold,
  input  logic                   credit_stall,
  input  logic                   pop,
  output logic                   head_valid,
  output credit_link_pkg::data_t head_data
);

  import credit_link_pkg::*;

  // Buffer storage and state.
  data_t mem [LANE_DEPTH];
  ptr_t  wr_ptr;
  ptr_t  rd_ptr;
  cnt_t  occupancy;

  // Write side, as seen after the credit receiver.
  logic  wr_en;
  data_t wr_data;

  // --------------------------------------------------
  // Credit receiver
  // --------------------------------------------------

  // The pop also acts as the credit return, so a freed slot is offered
  // to the sender again right away.
  credit_receiver receiver_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .push_credit_stall (credit_stall),
    .push_credit       (lane_credit),
    .push_valid        (lane_valid),
    .push_data         (lane_data),
    .pop_credit        (pop),
    .pop_valid         (wr_en),
    .pop_data          (wr_data),
    .credit_withhold   (credit_withhold),
    .credit_count      (),
    .credit_available  ()
  );

  // --------------------------------------------------
  // Circular buffer
  // --------------------------------------------------

  // Every write was covered by a credit, so there is always a free slot.
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      occupancy <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == ptr_t'(LANE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_t'(LANE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // A write and a pop in the same cycle leave the fill level unchanged.
      case ({wr_en, pop})
        2'b10:   occupancy <= occupancy + 1'b1;
        2'b01:   occupancy <= occupancy - 1'b1;
        default: occupancy <= occupancy;
      endcase
    end
  end

  // The head word is visible as soon as it sits in the buffer.
  assign head_valid = (occupancy != '0);
  assign head_data  = mem[rd_ptr];

endmodule

// ==== credit_sender.sv ====
`timescale 1ns/1ps

module credit_sender (
  input  logic                                   clk,
  input  logic                                   rst_n,
  // Input stream with valid/ready handshake.
  input  logic                                   in_valid,
  output logic                                   in_ready,
  input  credit_link_pkg::lane_t                 in_lane,
  input  credit_link_pkg::data_t                 in_data,
  // Credit/valid link toward the lanes.
  input  logic [credit_link_pkg::NUM_LANES-1:0]  lane_credit,
  output logic [credit_link_pkg::NUM_LANES-1:0]  lane_valid,
  output credit_link_pkg::data_t                 lane_data
);

  import credit_link_pkg::*;

  // Credits held for each lane.
  cnt_t [NUM_LANES-1:0] lane_cnt;

  logic                 accept;
  logic [NUM_LANES-1:0] lane_sel;

  // --------------------------------------------------
  // Input acceptance
  // --------------------------------------------------

  // A word may only enter when the sender holds a credit for its lane.
  // The counts are zero after reset, so in_ready starts low.
  assign in_ready = (lane_cnt[in_lane] != '0);
  assign accept   = in_valid && in_ready;

  // One-hot form of the addressed lane.
  assign lane_sel = NUM_LANES'(1) << in_lane;

  // --------------------------------------------------
  // Per-lane credit counts
  // --------------------------------------------------

  // A credit pulse and a push on the same lane can meet in one cycle.
  // They cancel out and the count stays as it was.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lane_cnt <= '0;
    end else begin
      for (int i = 0; i < NUM_LANES; i++) begin
        lane_cnt[i] <= lane_cnt[i]
                       + cnt_t'(lane_credit[i])
                       - cnt_t'(accept && lane_sel[i]);
      end
    end
  end

  // --------------------------------------------------
  // Push register
  // --------------------------------------------------

  // The accepted word goes out one cycle later with a one-hot valid.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lane_valid <= '0;
    end else begin
      lane_valid <= accept ? lane_sel : '0;
    end
  end

  // Payload is shared by all lanes and only the valid bit selects one.
  always_ff @(posedge clk) begin
    if (accept) begin
      lane_data <= in_data;
    end
  end

endmodule

// ==== flist.f ====
credit_link_pkg.sv
credit_counter.sv
credit_receiver.sv
credit_rx_lane.sv
credit_sender.sv
lane_drain_arbiter.sv
credit_link_top.sv
credit_link_checker.sv
tb_credit_link.sv

// ==== lane_drain_arbiter.sv ====
`timescale 1ns/1ps

module lane_drain_arbiter (
  input  logic                                                    clk,
  input  logic                                                    rst_n,
  // Heads of the lane buffers.
  input  logic [credit_link_pkg::NUM_LANES-1:0]                   head_valid,
  input  credit_link_pkg::data_t [credit_link_pkg::NUM_LANES-1:0] head_data,
  output logic [credit_link_pkg::NUM_LANES-1:0]                   pop,
  // Merged output stream with valid/ready handshake.
  output logic                                                    out_valid,
  input  logic                                                    out_ready,
  output credit_link_pkg::lane_t                                  out_lane,
  output credit_link_pkg::data_t                                  out_data
);

  import credit_link_pkg::*;

  // Lane that won the most recent grant.
  lane_t last_grant;

  lane_t grant_lane;
  logic  grant_found;
  logic  load_en;
  logic  grant;

  // --------------------------------------------------
  // Round-robin search
  // --------------------------------------------------

  // The search starts one lane past the last winner and wraps around.
  // The last winner itself is looked at last.
  always_comb begin
    int cand;
    grant_found = 1'b0;
    grant_lane  = last_grant;
    for (int k = 1; k <= NUM_LANES; k++) begin
      cand = (int'(last_grant) + k) % NUM_LANES;
      if (!grant_found && head_valid[cand]) begin
        grant_found = 1'b1;
        grant_lane  = lane_t'(cand);
      end
    end
  end

  // The output stage can take a word when it is empty or being drained.
  assign load_en = !out_valid || out_ready;
  assign grant   = grant_found && load_en;

  // Only the granted lane is popped, and only when the word can be stored.
  assign pop = grant ? (NUM_LANES'(1) << grant_lane) : '0;

  // --------------------------------------------------
  // Pointer and output stage
  // --------------------------------------------------

  // Lane 0 gets the first turn after reset.
  // The pointer moves only when some lane actually wins.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_grant <= lane_t'(NUM_LANES - 1);
      out_valid  <= 1'b0;
    end else begin
      if (grant) begin
        last_grant <= grant_lane;
      end
      if (load_en) begin
        out_valid <= grant_found;
      end
    end
  end

  // The word and its lane hold steady until out_ready takes them.
  always_ff @(posedge clk) begin
    if (grant) begin
      out_lane <= grant_lane;
      out_data <= head_data[grant_lane];
    end
  end

endmodule

// ==== tb_credit_link.sv ====
`timescale 1ns/1ps

module tb_credit_link;

  import credit_link_pkg::*;

  localparam int RESET_CYCLES = 8;
  localparam int IDLE_LIMIT   = 10;
  localparam int STALL_CYCLES = 20;
  localparam int MAX_LINES    = 64;
  // Fill tests 1, 3, 4 and 5 offer at most one word more than the depth per lane.
  localparam int FILL_WORDS   = 4 * NUM_LANES * (LANE_DEPTH + 1);

  logic  clk;
  logic  rst_n;
  logic  in_valid;
  logic  in_ready;
  lane_t in_lane;
  data_t in_data;
  cnt_t  credit_withhold;
  logic  credit_stall;
  logic  out_valid;
  logic  out_ready;
  lane_t out_lane;
  data_t out_data;

  // Each entry packs one file line as test, lane, and data or count.
  logic [23:0] vec [MAX_LINES];
  int          n_lines;
  int          n_words;
  int          cycle_count;
  int          cycle_limit;
  int          error_count;
  logic [31:0] lcg_state;

  // Monitor state is sampled on the rising edge.
  data_t exp_q [NUM_LANES][$];
  int    accepted [NUM_LANES];
  logic  in_fire;
  logic  ready_seen;
  logic  rotate_check;
  logic  have_prev;
  lane_t prev_lane;
  int    out_words;

  credit_link_top dut_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .in_valid        (in_valid),
    .in_ready        (in_ready),
    .in_lane         (in_lane),
    .in_data         (in_data),
    .credit_withhold (credit_withhold),
    .credit_stall    (credit_stall),
    .out_valid       (out_valid),
    .out_ready       (out_ready),
    .out_lane        (out_lane),
    .out_data        (out_data)
  );

  always #5 clk = ~clk;

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_lane(input string name, input lane_t got, input lane_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_count(input string name, input cnt_t got, input cnt_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      error_count++;
    end
  endtask

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------

  // LCG draw for out_ready. Ready is high about three cycles in four.
  function automatic logic ready_draw();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return (lcg_state[17:16] != 2'b00);
  endfunction

  // Fill words carry their lane in the top nibble, which makes a misrouted word obvious.
  function automatic data_t fill_word(input lane_t lane, input int seq);
    return data_t'((int'(lane) << 12) | (seq & 12'hfff));
  endfunction

  function automatic cnt_t expected_count(input int test);
    cnt_t result;
    result = '0;
    for (int n = 0; n < n_lines; n++) begin
      if (int'(vec[n][23:20]) == test) begin
        result = cnt_t'(vec[n][15:0]);
      end
    end
    return result;
  endfunction

  function automatic int sent_total();
    int sum;
    sum = 0;
    for (int i = 0; i < NUM_LANES; i++) begin
      sum += accepted[i];
    end
    return sum;
  endfunction

  function automatic int assert_failures();
    return dut_i.gen_lane[0].lane_i.receiver_i.checker_i.fail_count
         + dut_i.gen_lane[1].lane_i.receiver_i.checker_i.fail_count
         + dut_i.gen_lane[2].lane_i.receiver_i.checker_i.fail_count
         + dut_i.gen_lane[3].lane_i.receiver_i.checker_i.fail_count;
  endfunction

  // --------------------------------------------------
  // Monitor
  // --------------------------------------------------

  // Each output word must match the oldest word still expected on its lane.
  task automatic take_output();
    if (exp_q[out_lane].size() == 0) begin
      $display("Output word %h on lane %0d was never sent or came out twice", out_data, out_lane);
      error_count++;
    end else begin
      check_data("out_data", out_data, exp_q[out_lane].pop_front());
    end
    if (rotate_check && have_prev) begin
      check_lane("out_lane", out_lane, lane_t'(prev_lane + 1));
    end
    have_prev = 1'b1;
    prev_lane = out_lane;
    out_words++;
  endtask

  // Inputs change only on the falling edge, so they are steady here.
  always @(posedge clk) begin
    if (!rst_n) begin
      in_fire    = 1'b0;
      ready_seen = 1'b0;
    end else begin
      in_fire    = in_valid && in_ready;
      ready_seen = in_ready;
      if (in_fire) begin
        accepted[in_lane]++;
        exp_q[in_lane].push_back(in_data);
      end
      if (out_valid && out_ready) begin
        take_output();
      end
    end
  end

  // --------------------------------------------------
  // Stimulus tasks
  // --------------------------------------------------

  task automatic reset_dut(input cnt_t withhold, input logic stall);
    @(negedge clk);
    rst_n           = 1'b0;
    in_valid        = 1'b0;
    in_lane         = '0;
    in_data         = '0;
    out_ready       = 1'b0;
    credit_withhold = withhold;
    credit_stall    = stall;
    for (int i = 0; i < NUM_LANES; i++) begin
      exp_q[i].delete();
      accepted[i] = 0;
    end
    rotate_check = 1'b0;
    have_prev    = 1'b0;
    out_words    = 0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
  endtask

  // Offer words to one lane until in_ready has stayed low for IDLE_LIMIT cycles.
  task automatic fill_lane(input lane_t lane);
    int idle;
    int seq;
    idle     = 0;
    seq      = 0;
    in_valid = 1'b1;
    in_lane  = lane;
    in_data  = fill_word(lane, seq);
    while (idle < IDLE_LIMIT) begin
      @(negedge clk);
      if (in_fire) begin
        idle    = 0;
        seq++;
        in_data = fill_word(lane, seq);
      end else begin
        idle++;
      end
    end
    in_valid = 1'b0;
  endtask

  task automatic fill_all_lanes();
    for (int i = 0; i < NUM_LANES; i++) begin
      fill_lane(lane_t'(i));
    end
  endtask

  // The output stage holds one word beyond the lane buffers, so it is taken off here.
  task automatic check_fill(input cnt_t expected);
    cnt_t held;
    for (int i = 0; i < NUM_LANES; i++) begin
      held = cnt_t'(accepted[i]);
      if (out_valid && out_lane == lane_t'(i)) begin
        held = held - 1'b1;
      end
      check_count($sformatf("held count of lane %0d", i), held, expected);
    end
  endtask

  task automatic stream_words();
    for (int n = 0; n < n_lines; n++) begin
      if (vec[n][23:20] == 4'h2) begin
        in_valid = 1'b1;
        in_lane  = lane_t'(vec[n][19:16]);
        in_data  = data_t'(vec[n][15:0]);
        do begin
          out_ready = ready_draw();
          @(negedge clk);
        end while (!in_fire);
      end
    end
    in_valid = 1'b0;
  endtask

  task automatic drain_all();
    out_ready = 1'b1;
    while (out_words < sent_total()) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);
    check_flag("out_valid", out_valid, 1'b0);
    if (out_words != sent_total()) begin
      $display("%0d words came out but %0d went in", out_words, sent_total());
      error_count++;
    end
    for (int i = 0; i < NUM_LANES; i++) begin
      if (exp_q[i].size() != 0) begin
        $display("Lane %0d kept %0d accepted words that never came out", i, exp_q[i].size());
        error_count++;
      end
    end
  endtask

  task automatic finish_run();
    int asserts;
    asserts = assert_failures();
    $display("Check errors: %0d, assertion failures: %0d", error_count, asserts);
    if (error_count == 0 && asserts == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------

  initial begin
    clk             = 1'b0;
    rst_n           = 1'b0;
    in_valid        = 1'b0;
    in_lane         = '0;
    in_data         = '0;
    credit_withhold = '0;
    credit_stall    = 1'b0;
    out_ready       = 1'b0;
    error_count     = 0;
    cycle_count     = 0;
    lcg_state       = 32'hd407;
    for (int n = 0; n < MAX_LINES; n++) begin
      vec[n] = 24'hf00000;
    end
    $readmemh("credit_link_testdata.txt", vec);
    // The file ends at the first line with test number f.
    n_lines = 0;
    n_words = 0;
    while (n_lines < MAX_LINES && vec[n_lines][23:20] != 4'hf) begin
      if (vec[n_lines][23:20] == 4'h2) begin
        n_words++;
      end
      n_lines++;
    end
    cycle_limit = (n_words + FILL_WORDS) * 20 + 200;
    if (n_words == 0) begin
      $display("The test data file held no stream words");
      error_count++;
    end

    // Test 1 fills every lane against a blocked output.
    reset_dut('0, 1'b0);
    fill_all_lanes();
    check_fill(expected_count(1));

    // Test 2 streams the file words through random back-pressure.
    reset_dut('0, 1'b0);
    stream_words();
    drain_all();

    // Test 3 drains four full lanes, which must come out in turn.
    reset_dut('0, 1'b0);
    fill_all_lanes();
    rotate_check = 1'b1;
    drain_all();

    // Test 4 is test 1 with one credit withheld per lane.
    reset_dut(cnt_t'(1), 1'b0);
    fill_all_lanes();
    check_fill(expected_count(4));
    // With the whole depth withheld, every credit that the drain returns
    // must stay in its lane.
    credit_withhold = cnt_t'(LANE_DEPTH);
    drain_all();

    // Test 5 holds the stall from reset, then lets the lanes fill.
    reset_dut('0, 1'b1);
    in_valid = 1'b1;
    for (int k = 0; k < STALL_CYCLES; k++) begin
      in_lane = lane_t'(k % NUM_LANES);
      in_data = fill_word(in_lane, k);
      @(negedge clk);
      check_flag("in_ready", ready_seen, 1'b0);
    end
    in_valid     = 1'b0;
    credit_stall = 1'b0;
    fill_all_lanes();
    check_fill(expected_count(5));

    finish_run();
  end

  // The limit is read on the first edge, after the data file has been loaded.
  initial begin : watchdog
    @(posedge clk);
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not end within %0d clock cycles", cycle_limit);
    error_count++;
    finish_run();
  end

endmodule
